/* deputy_consts.svh */
`ifndef DEPUTY_CONSTS_SVH
`define DEPUTY_CONSTS_SVH

// regular alu operations
`define ALU_ADDW       8'h10
`define ALU_SUBW       8'h11
`define ALU_SLT        8'h12
`define ALU_SLTU       8'h13
`define ALU_AND        8'h14
`define ALU_OR         8'h15
`define ALU_NOR        8'h16
`define ALU_XOR        8'h17
`define ALU_SLLW       8'h18
`define ALU_SRLW       8'h19
`define ALU_SRAW       8'h1a
`define ALU_LU12I      8'h1b
`define ALU_PCADDU12I  8'h1c

// divider operations
`define ALU_DIVW       8'h20
`define ALU_MODW       8'h21
`define ALU_DIVWU      8'h22
`define ALU_MODWU      8'h23

// branches and jumps
`define ALU_BEQ        8'h30
`define ALU_BNE        8'h31
`define ALU_BLT        8'h32
`define ALU_BGE        8'h33
`define ALU_BLTU       8'h34
`define ALU_BGEU       8'h35
`define ALU_B          8'h36
`define ALU_BL         8'h37
`define ALU_JIRL       8'h38

// unit selects
`define ALU_SEL_NOP          3'd0
`define ALU_SEL_LOGIC        3'd1
`define ALU_SEL_SHIFT        3'd2
`define ALU_SEL_ARITHMETIC   3'd3
`define ALU_SEL_DIV          3'd4
`define ALU_SEL_JUMP_BRANCH  3'd5

`define DIV_CYCLES 32

`endif

/* pipeline_types.sv */
package pipeline_types;

    typedef logic [31:0] bus32_t;
    typedef logic [7:0]  aluop_t;
    typedef logic [2:0]  alusel_t;
    typedef logic [4:0]  reg_addr_t;

    // one instruction as it leaves dispatch
    typedef struct packed {
        bus32_t          pc;
        bus32_t          inst;
        logic            inst_valid;
        aluop_t          aluop;
        alusel_t         alusel;
        bus32_t [1:0]    reg_data;
        logic            reg_write_en;
        reg_addr_t       reg_write_addr;
        logic            is_exception;
        logic            pre_is_branch_taken;
        bus32_t          pre_branch_addr;
    } dispatch_ex_t;

    // execute result towards the memory stage
    typedef struct packed {
        bus32_t          pc;
        bus32_t          inst;
        logic            inst_valid;
        aluop_t          aluop;
        logic            is_exception;
        logic            reg_write_en;
        reg_addr_t       reg_write_addr;
        bus32_t          reg_write_data;
    } ex_mem_t;

    // predictor update
    typedef struct packed {
        logic            valid;
        bus32_t          pc;
        logic            is_taken;
        bus32_t          branch_actual_addr;
        logic            is_call;
        logic            is_return;
    } branch_update;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

/* dispatch_latch.sv */
`timescale 1ns/10ps

module dispatch_latch (
    input  logic                        clk,
    input  logic                        reset_i,
    input  pipeline_types::dispatch_ex_t dispatch_i,
    input  logic                        stall_i,
    input  logic                        flush_i,
    output pipeline_types::dispatch_ex_t ex_o
);

    // only the valid bit is cleared, the payload is don't care
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_o.inst_valid <= 1'b0;
        end
        else if (flush_i) begin
            // wrong path instruction is dropped here
            ex_o.inst_valid <= 1'b0;
        end
        else if (!stall_i) begin
            ex_o <= dispatch_i;
        end
    end

endmodule

/* regular_alu.sv */
`timescale 1ns/10ps
`include "deputy_consts.svh"

module regular_alu (
    input  pipeline_types::aluop_t  aluop_i,
    input  pipeline_types::alusel_t alusel_i,
    input  pipeline_types::bus32_t  reg1_i,
    input  pipeline_types::bus32_t  reg2_i,
    output pipeline_types::bus32_t  result_o
);

    logic [4:0] shamt;

    assign shamt = reg2_i[4:0];

    always_comb begin
        result_o = 32'b0;
        case (alusel_i)
            `ALU_SEL_LOGIC: begin
                case (aluop_i)
                    `ALU_AND: result_o = reg1_i & reg2_i;
                    `ALU_OR:  result_o = reg1_i | reg2_i;
                    `ALU_NOR: result_o = ~(reg1_i | reg2_i);
                    `ALU_XOR: result_o = reg1_i ^ reg2_i;
                    default:  result_o = 32'b0;
                endcase
            end
            `ALU_SEL_SHIFT: begin
                case (aluop_i)
                    `ALU_SLLW: result_o = reg1_i << shamt;
                    `ALU_SRLW: result_o = reg1_i >> shamt;
                    `ALU_SRAW: result_o = $signed(reg1_i) >>> shamt;
                    default:   result_o = 32'b0;
                endcase
            end
            `ALU_SEL_ARITHMETIC: begin
                case (aluop_i)
                    // pcaddu12i gets the pc as first operand from the core
                    `ALU_ADDW, `ALU_PCADDU12I: result_o = reg1_i + reg2_i;
                    `ALU_SUBW:  result_o = reg1_i - reg2_i;
                    `ALU_SLT:   result_o = {31'b0, $signed(reg1_i) < $signed(reg2_i)};
                    `ALU_SLTU:  result_o = {31'b0, reg1_i < reg2_i};
                    `ALU_LU12I: result_o = reg2_i;
                    default:    result_o = 32'b0;
                endcase
            end
            default: begin
                result_o = 32'b0;
            end
        endcase
    end

endmodule

/* div_alu.sv */
`timescale 1ns/10ps
`include "deputy_consts.svh"

module div_alu (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   signed_i,
    input  pipeline_types::bus32_t dividend_i,
    input  pipeline_types::bus32_t divisor_i,
    input  logic                   start_i,
    output logic                   busy_o,
    output logic                   done_o,
    output pipeline_types::bus32_t quotient_o,
    output pipeline_types::bus32_t remainder_o
);

    import pipeline_types::*;

    div_state_t state;
    logic [5:0] cnt;
    bus32_t     quot;
    bus32_t     rem;
    bus32_t     divisor_r;
    bus32_t     dividend_r;
    bus32_t     abs_dividend;
    bus32_t     abs_divisor;
    logic       neg_q;
    logic       neg_r;
    logic       div_zero;
    logic [32:0] shifted;
    logic       fit;

    assign abs_dividend = (signed_i && dividend_i[31]) ? -dividend_i : dividend_i;
    assign abs_divisor  = (signed_i && divisor_i[31]) ? -divisor_i : divisor_i;

    // one restoring step per cycle
    assign shifted = {rem, quot[31]};
    assign fit     = shifted >= {1'b0, divisor_r};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= DIV_IDLE;
            cnt   <= 6'd0;
        end
        else begin
            case (state)
                DIV_IDLE: begin
                    if (start_i) begin
                        state <= DIV_RUN;
                        cnt   <= 6'd0;
                    end
                end
                DIV_RUN: begin
                    cnt <= cnt + 6'd1;
                    if (cnt == 6'(`DIV_CYCLES - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start_i) begin
            quot       <= abs_dividend;
            rem        <= 32'b0;
            divisor_r  <= abs_divisor;
            dividend_r <= dividend_i;
            neg_q      <= signed_i && (dividend_i[31] ^ divisor_i[31]);
            neg_r      <= signed_i && dividend_i[31];
            div_zero   <= (divisor_i == 32'b0);
        end
        else if (state == DIV_RUN) begin
            quot <= {quot[30:0], fit};
            rem  <= fit ? 32'(shifted - {1'b0, divisor_r}) : shifted[31:0];
        end
    end

    assign busy_o = (state == DIV_RUN);
    assign done_o = (state == DIV_DONE);

    // sign fixup, min / -1 comes out right without a special case
    assign quotient_o  = div_zero ? 32'hffff_ffff : (neg_q ? -quot : quot);
    assign remainder_o = div_zero ? dividend_r : (neg_r ? -rem : rem);

endmodule

/* branch_alu.sv */
`timescale 1ns/10ps
`include "deputy_consts.svh"

module branch_alu (
    input  pipeline_types::bus32_t       pc_i,
    input  pipeline_types::bus32_t       inst_i,
    input  pipeline_types::aluop_t       aluop_i,
    input  logic                         valid_i,
    input  pipeline_types::bus32_t       reg1_i,
    input  pipeline_types::bus32_t       reg2_i,
    input  logic                         pre_taken_i,
    input  pipeline_types::bus32_t       pre_addr_i,
    output pipeline_types::branch_update update_o,
    output logic                         flush_o,
    output pipeline_types::bus32_t       link_o
);

    import pipeline_types::*;

    bus32_t off16;
    bus32_t off26;
    bus32_t target;
    logic   is_branch;
    logic   taken;

    assign off16 = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
    assign off26 = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};
    assign link_o = pc_i + 32'd4;

    always_comb begin
        is_branch = 1'b1;
        taken     = 1'b0;
        target    = pc_i + off16;
        case (aluop_i)
            `ALU_BEQ:  taken = (reg1_i == reg2_i);
            `ALU_BNE:  taken = (reg1_i != reg2_i);
            `ALU_BLT:  taken = ($signed(reg1_i) < $signed(reg2_i));
            `ALU_BGE:  taken = ($signed(reg1_i) >= $signed(reg2_i));
            `ALU_BLTU: taken = (reg1_i < reg2_i);
            `ALU_BGEU: taken = (reg1_i >= reg2_i);
            `ALU_B, `ALU_BL: begin
                taken  = 1'b1;
                target = pc_i + off26;
            end
            `ALU_JIRL: begin
                taken  = 1'b1;
                target = reg1_i + off16;
            end
            default: is_branch = 1'b0;
        endcase
    end

    // wrong direction, or taken to the wrong place
    assign flush_o = valid_i && is_branch
                     && ((taken != pre_taken_i) || (taken && target != pre_addr_i));

    assign update_o.valid              = valid_i && is_branch;
    assign update_o.pc                 = pc_i;
    assign update_o.is_taken           = taken;
    assign update_o.branch_actual_addr = taken ? target : link_o;
    assign update_o.is_call            = (aluop_i == `ALU_BL);
    assign update_o.is_return          = (aluop_i == `ALU_JIRL)
                                         && inst_i[9:5] == 5'd1 && inst_i[4:0] == 5'd0;

endmodule

/* deputy_ex.sv */
`timescale 1ns/10ps
`include "deputy_consts.svh"

module deputy_ex (
    input  logic                         clk,
    input  logic                         reset_i,
    input  pipeline_types::dispatch_ex_t ex_i,
    output pipeline_types::ex_mem_t      ex_o,
    output pipeline_types::branch_update update_o,
    output logic                         stall_o,
    output logic                         branch_flush_o,
    output pipeline_types::bus32_t       branch_target_o
);

    import pipeline_types::*;

    bus32_t reg1;
    bus32_t regular_res;
    bus32_t link;
    bus32_t quotient;
    bus32_t remainder;
    logic   is_div;
    logic   is_mod;
    logic   div_signed;
    logic   start_div;
    logic   div_busy;
    logic   div_done;

    assign reg1 = (ex_i.aluop == `ALU_PCADDU12I) ? ex_i.pc : ex_i.reg_data[0];

    regular_alu regular_alu_inst (
        .aluop_i  (ex_i.aluop),
        .alusel_i (ex_i.alusel),
        .reg1_i   (reg1),
        .reg2_i   (ex_i.reg_data[1]),
        .result_o (regular_res)
    );

    // divider decode
    assign is_mod = (ex_i.aluop == `ALU_MODW) || (ex_i.aluop == `ALU_MODWU);
    assign is_div = is_mod || (ex_i.aluop == `ALU_DIVW) || (ex_i.aluop == `ALU_DIVWU);
    assign div_signed = (ex_i.aluop == `ALU_DIVW) || (ex_i.aluop == `ALU_MODW);

    // the latch valid bit marks a fresh divide
    assign start_div = ex_i.inst_valid && is_div && !div_busy && !div_done;

    div_alu div_alu_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .signed_i    (div_signed),
        .dividend_i  (ex_i.reg_data[0]),
        .divisor_i   (ex_i.reg_data[1]),
        .start_i     (start_div),
        .busy_o      (div_busy),
        .done_o      (div_done),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    branch_alu branch_alu_inst (
        .pc_i        (ex_i.pc),
        .inst_i      (ex_i.inst),
        .aluop_i     (ex_i.aluop),
        .valid_i     (ex_i.inst_valid),
        .reg1_i      (ex_i.reg_data[0]),
        .reg2_i      (ex_i.reg_data[1]),
        .pre_taken_i (ex_i.pre_is_branch_taken),
        .pre_addr_i  (ex_i.pre_branch_addr),
        .update_o    (update_o),
        .flush_o     (branch_flush_o),
        .link_o      (link)
    );

    assign branch_target_o = update_o.branch_actual_addr;
    assign stall_o = start_div || div_busy;

    always_comb begin
        ex_o.pc             = ex_i.pc;
        ex_o.inst           = ex_i.inst;
        ex_o.inst_valid     = ex_i.inst_valid;
        ex_o.aluop          = ex_i.aluop;
        ex_o.is_exception   = ex_i.is_exception;
        ex_o.reg_write_en   = ex_i.reg_write_en;
        ex_o.reg_write_addr = ex_i.reg_write_addr;
        case (ex_i.alusel)
            `ALU_SEL_LOGIC, `ALU_SEL_SHIFT, `ALU_SEL_ARITHMETIC: begin
                ex_o.reg_write_data = regular_res;
            end
            // only taken downstream in the done cycle
            `ALU_SEL_DIV:         ex_o.reg_write_data = is_mod ? remainder : quotient;
            `ALU_SEL_JUMP_BRANCH: ex_o.reg_write_data = link;
            default:              ex_o.reg_write_data = 32'b0;
        endcase
    end

endmodule

/* ex_mem_reg.sv */
`timescale 1ns/10ps

module ex_mem_reg (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    stall_i,
    input  pipeline_types::ex_mem_t ex_i,
    output pipeline_types::ex_mem_t mem_o
);

    // bubble while the core is stalled so a divide is written once
    always_ff @(posedge clk) begin
        if (reset_i || stall_i) begin
            mem_o.inst_valid <= 1'b0;
        end
        else begin
            mem_o <= ex_i;
        end
    end

endmodule

/* deputy_ex_top.sv */
`timescale 1ns/10ps

module deputy_ex_top (
    input  logic                         clk,
    input  logic                         reset_i,
    input  pipeline_types::dispatch_ex_t dispatch_i,
    output pipeline_types::ex_mem_t      mem_o,
    output pipeline_types::branch_update update_o,
    output logic                         stall_o,
    output logic                         branch_flush_o,
    output pipeline_types::bus32_t       branch_target_o
);

    import pipeline_types::*;

    dispatch_ex_t ex_cur;
    ex_mem_t      ex_res;

    dispatch_latch dispatch_latch_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .dispatch_i (dispatch_i),
        .stall_i    (stall_o),
        .flush_i    (branch_flush_o),
        .ex_o       (ex_cur)
    );

    deputy_ex deputy_ex_inst (
        .clk             (clk),
        .reset_i         (reset_i),
        .ex_i            (ex_cur),
        .ex_o            (ex_res),
        .update_o        (update_o),
        .stall_o         (stall_o),
        .branch_flush_o  (branch_flush_o),
        .branch_target_o (branch_target_o)
    );

    ex_mem_reg ex_mem_reg_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (stall_o),
        .ex_i    (ex_res),
        .mem_o   (mem_o)
    );

endmodule

/* deputy_ex_properties.sv */
`timescale 1ns/10ps
`include "deputy_consts.svh"

module deputy_ex_properties (
    input logic                    clk,
    input logic                    reset_i,
    input logic                    stall_o,
    input logic                    div_done,
    input logic                    branch_flush_o,
    input logic                    ex_valid,
    input pipeline_types::alusel_t ex_alusel
);

    logic [7:0] stall_run;

    always_ff @(posedge clk) begin
        if (reset_i || !stall_o) begin
            stall_run <= 8'd0;
        end
        else begin
            stall_run <= stall_run + 8'd1;
        end
    end

    // a divide stalls for start plus 32 busy cycles
    stall_bounded: assert property (@(posedge clk) disable iff (reset_i) stall_run <= 8'd34)
        else $error("stall held longer than a divide");

    // done follows exactly 33 stalled cycles
    done_in_step: assert property (@(posedge clk) disable iff (reset_i)
        div_done |-> stall_run == 8'd33)
        else $error("divider done out of step with the stall");

    flush_needs_branch: assert property (@(posedge clk) disable iff (reset_i)
        branch_flush_o |-> ex_valid && ex_alusel == `ALU_SEL_JUMP_BRANCH)
        else $error("flush without a valid branch");

endmodule

bind deputy_ex deputy_ex_properties deputy_ex_properties_inst (
    .clk            (clk),
    .reset_i        (reset_i),
    .stall_o        (stall_o),
    .div_done       (div_done),
    .branch_flush_o (branch_flush_o),
    .ex_valid       (ex_i.inst_valid),
    .ex_alusel      (ex_i.alusel)
);

/* tb_deputy_ex.sv */
`timescale 1ns/10ps
`include "deputy_consts.svh"

module tb_deputy_ex;

    import pipeline_types::*;

    localparam int N_PAT = 31;
    localparam int N_COL = 12;

    logic         clk;
    logic         reset_i;
    dispatch_ex_t dispatch_i;
    ex_mem_t      mem_o;
    branch_update update_o;
    logic         stall_o;
    logic         branch_flush_o;
    bus32_t       branch_target_o;

    bus32_t    pat [0:N_PAT*N_COL-1];
    bus32_t    exp_data_q[$];
    reg_addr_t exp_dest_q[$];
    bus32_t    exp_pc_q[$];
    int        exp_cycle_q[$];
    int        cycle_cnt;

    deputy_ex_top deputy_ex_top_inst (
        .clk             (clk),
        .reset_i         (reset_i),
        .dispatch_i      (dispatch_i),
        .mem_o           (mem_o),
        .update_o        (update_o),
        .stall_o         (stall_o),
        .branch_flush_o  (branch_flush_o),
        .branch_target_o (branch_target_o)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // rising edges seen so far
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check(input string name, input bus32_t got, input bus32_t expv);
        if (got !== expv) begin
            $display("ERR %s got %h expected %h", name, got, expv);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    // returns just after the edge where the latch took the item
    task automatic wait_accept();
        int   cycles;
        logic held;
        cycles = 0;
        held   = 1'b1;
        while (held) begin
            held = stall_o;
            @(posedge clk);
            #1;
            cycles++;
            if (held && cycles > 100) begin
                abort_run("timeout: stage never accepted the instruction");
            end
        end
    endtask

    function automatic dispatch_ex_t item_from_pattern(input int idx);
        dispatch_ex_t item;
        int           b;
        b = idx * N_COL;
        item                     = '0;
        item.inst_valid          = 1'b1;
        item.aluop               = pat[b][7:0];
        item.alusel              = pat[b+1][2:0];
        item.pc                  = pat[b+2];
        item.inst                = pat[b+3];
        item.reg_data[0]         = pat[b+4];
        item.reg_data[1]         = pat[b+5];
        item.reg_write_en        = 1'b1;
        item.reg_write_addr      = pat[b+6][4:0];
        item.pre_is_branch_taken = pat[b+7][0];
        item.pre_branch_addr     = pat[b+8];
        return item;
    endfunction

    // results arrive in dispatch order
    always @(negedge clk) begin : result_monitor
        bus32_t    exp_d;
        reg_addr_t exp_a;
        bus32_t    exp_pc;
        int        exp_c;
        if (!reset_i && mem_o.inst_valid) begin
            if (exp_data_q.size() == 0) begin
                abort_run("unexpected valid result on mem_o");
            end
            else begin
                exp_d  = exp_data_q.pop_front();
                exp_a  = exp_dest_q.pop_front();
                exp_pc = exp_pc_q.pop_front();
                exp_c  = exp_cycle_q.pop_front();
                check("mem_o.pc", mem_o.pc, exp_pc);
                check("mem_o.reg_write_data", mem_o.reg_write_data, exp_d);
                check("mem_o.reg_write_addr", {27'b0, mem_o.reg_write_addr}, {27'b0, exp_a});
                if (exp_c >= 0) begin
                    check("mem_o.inst_valid cycle", cycle_cnt, exp_c);
                end
            end
        end
    end

    initial begin : stimulus
        dispatch_ex_t item;
        bus32_t       exp_tgt;
        logic         exp_flush;
        logic         is_branch;
        logic         is_div;
        logic         squash;
        logic         is_ret;
        int           cycles;
        reset_i     = 1'b1;
        dispatch_i  = '0;
        squash      = 1'b0;
        cycle_cnt   = 0;
        $readmemh("deputy_patterns.mem", pat);
        repeat (8) @(posedge clk);
        #1 reset_i = 1'b0;
        check("{stall_o,branch_flush_o,update_o.valid,mem_o.inst_valid}",
              {28'b0, stall_o, branch_flush_o, update_o.valid, mem_o.inst_valid}, 32'd0);
        for (int p = 0; p < N_PAT; p++) begin
            item       = item_from_pattern(p);
            exp_tgt    = pat[p*N_COL+11];
            exp_flush  = pat[p*N_COL+10][0];
            is_branch  = (item.alusel == `ALU_SEL_JUMP_BRANCH);
            is_div     = (item.alusel == `ALU_SEL_DIV);
            dispatch_i = item;
            wait_accept();
            if (squash) begin
                // this one was on the wrong path
                squash = 1'b0;
            end
            else begin
                exp_data_q.push_back(pat[p*N_COL+9]);
                exp_dest_q.push_back(item.reg_write_addr);
                exp_pc_q.push_back(item.pc);
                exp_cycle_q.push_back(is_div ? -1 : cycle_cnt + 1);
                check("stall_o", {31'b0, stall_o}, {31'b0, is_div});
                check("branch_flush_o", {31'b0, branch_flush_o}, {31'b0, exp_flush});
                check("update_o.valid", {31'b0, update_o.valid}, {31'b0, is_branch});
                if (is_branch) begin
                    is_ret = (item.aluop == `ALU_JIRL) && item.inst[9:5] == 5'd1
                             && item.reg_write_addr == 5'd0;
                    check("update_o.pc", update_o.pc, item.pc);
                    check("update_o.branch_actual_addr", update_o.branch_actual_addr, exp_tgt);
                    check("update_o.is_taken", {31'b0, update_o.is_taken},
                          {31'b0, exp_tgt != item.pc + 32'd4});
                    check("update_o.is_call", {31'b0, update_o.is_call},
                          {31'b0, item.aluop == `ALU_BL});
                    check("update_o.is_return", {31'b0, update_o.is_return}, {31'b0, is_ret});
                    if (exp_flush) begin
                        check("branch_target_o", branch_target_o, exp_tgt);
                    end
                end
                squash = exp_flush;
            end
        end
        dispatch_i.inst_valid = 1'b0;
        cycles = 0;
        while (exp_data_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 100) begin
                abort_run("timeout: expected results never reached mem_o");
            end
        end
        repeat (4) @(posedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
pipeline_types.sv
dispatch_latch.sv
regular_alu.sv
div_alu.sv
branch_alu.sv
deputy_ex.sv
ex_mem_reg.sv
deputy_ex_top.sv
deputy_ex_properties.sv
tb_deputy_ex.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, then run and look for the pass message
verilator --binary --timing -f flist.f --top-module tb_deputy_ex -o sim_deputy_ex \
    && ./obj_dir/sim_deputy_ex | grep -q "all tests passed" \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }

/* deputy_patterns.mem */
// aluop alusel pc inst op1 op2 dest pre_taken pre_addr
//   then expected write data, expected flush, expected branch target
10 3 00001000 00000000 00000005 fffffffe 01 0 00000000 00000003 0 00000000
11 3 00001004 00000000 00000003 00000005 02 0 00000000 fffffffe 0 00000000
12 3 00001008 00000000 ffffffff 00000001 03 0 00000000 00000001 0 00000000
13 3 0000100c 00000000 ffffffff 00000001 04 0 00000000 00000000 0 00000000
14 1 00001010 00000000 f0f0ff00 0ff00ff0 05 0 00000000 00f00f00 0 00000000
15 1 00001014 00000000 f0f0ff00 0ff00ff0 06 0 00000000 fff0fff0 0 00000000
16 1 00001018 00000000 f0f0ff00 0ff00ff0 07 0 00000000 000f000f 0 00000000
17 1 0000101c 00000000 f0f0ff00 0ff00ff0 08 0 00000000 ff00f0f0 0 00000000
18 2 00001020 00000000 80000011 00000024 09 0 00000000 00000110 0 00000000
19 2 00001024 00000000 80000010 00000024 0a 0 00000000 08000001 0 00000000
1a 2 00001028 00000000 80000010 00000024 0b 0 00000000 f8000001 0 00000000
1b 3 0000102c 00000000 deadbeef 12345000 0c 0 00000000 12345000 0 00000000
1c 3 00001040 00000000 deadbeef 00002000 0d 0 00000000 00003040 0 00000000
30 5 00002000 00001000 00000005 00000005 00 1 00002010 00002004 0 00002010
31 5 00002100 00001000 00000005 00000005 00 0 00000000 00002104 0 00002104
32 5 00002200 00001000 00000005 00000003 00 1 00002210 00002204 1 00002204
10 3 00002204 00000000 00000001 00000001 0e 0 00000000 00000000 0 00000000
35 5 00002300 00001000 ffffffff 00000001 00 0 00000000 00002304 1 00002310
10 3 00002304 00000000 00000001 00000001 0e 0 00000000 00000000 0 00000000
38 5 00002400 00001020 00008000 00000000 00 1 00009000 00002404 1 00008010
10 3 00002404 00000000 00000001 00000001 0e 0 00000000 00000000 0 00000000
37 5 00002500 00001000 00000000 00000000 01 1 00002510 00002504 0 00002510
20 4 00002600 00000000 fffffff9 00000002 10 0 00000000 fffffffd 0 00000000
21 4 00002604 00000000 fffffff9 00000002 11 0 00000000 ffffffff 0 00000000
22 4 00002608 00000000 fffffff9 00000002 12 0 00000000 7ffffffc 0 00000000
23 4 0000260c 00000000 fffffff9 00000002 13 0 00000000 00000001 0 00000000
20 4 00002610 00000000 00000064 00000000 14 0 00000000 ffffffff 0 00000000
21 4 00002614 00000000 00000064 00000000 15 0 00000000 00000064 0 00000000
20 4 00002618 00000000 80000000 ffffffff 16 0 00000000 80000000 0 00000000
21 4 0000261c 00000000 80000000 ffffffff 17 0 00000000 00000000 0 00000000
10 3 00002620 00000000 00000001 00000002 18 0 00000000 00000003 0 00000000
